// File: Bender.yml
package:
  name: serial_link_lite

sources:
  - target: rtl
    files:
      - source/link_format_pkg.sv
      - source/link_ctrl_pkg.sv
      - source/link_fifo.sv
      - source/link_tx.sv
      - source/link_rx.sv
      - source/serial_link_data_link.sv
  - target: test
    files:
      - verification/tb_serial_link_data_link.sv

// File: serial_link_lite.f
source/link_format_pkg.sv
source/link_ctrl_pkg.sv
source/link_fifo.sv
source/link_tx.sv
source/link_rx.sv
source/serial_link_data_link.sv
verification/tb_serial_link_data_link.sv

// File: source/link_ctrl_pkg.sv
/*
  Serial link control encodings
  Send FSM states and channel select and mask types
*/
package link_ctrl_pkg;

  // Producer framing FSM
  typedef enum logic {
    LinkSendIdle,
    LinkSendBusy
  } link_send_state_e;

  // Index of a single channel
  typedef logic [$clog2(link_format_pkg::NumChannels)-1:0] chan_sel_t;
  // One bit per channel
  typedef logic [link_format_pkg::NumChannels-1:0] chan_mask_t;

endpackage

// File: source/link_fifo.sv
/*
  Link FIFO
  Synchronous circular buffer with flush, full, empty and usage count
*/
`timescale 1ns/1ps

module link_fifo #(
  parameter int DataWidth = 32,
  parameter int Depth     = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  logic [DataWidth-1:0]      data_i,
  input  logic                      pop_i,
  output logic [DataWidth-1:0]      data_o,
  output logic                      full_o,
  output logic                      empty_o,
  output logic [$clog2(Depth):0]    usage_o
);

  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [DataWidth-1:0]   mem_q [Depth];
  logic [AddrWidth-1:0]   rd_ptr_q, wr_ptr_q;
  logic [$clog2(Depth):0] count_q;
  logic                   do_push, do_pop;

  // Pointer advance with wrap for any depth
  function automatic logic [AddrWidth-1:0] next_ptr(input logic [AddrWidth-1:0] ptr);
    if (ptr == AddrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == ($clog2(Depth)+1)'(Depth));
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  // Head word, only meaningful while not empty
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o & ~flush_i;
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  ////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: source/link_format_pkg.sv
/*
  Serial link data format
  Widths, sizes and vector types shared by the framing logic and the FIFOs
*/
package link_format_pkg;

  ////////////////////////////////////////////////////////////
  // PHY geometry
  ////////////////////////////////////////////////////////////

  localparam int NumChannels  = 2;
  localparam int NumLanes     = 8;
  // Double data rate, two bits per lane and clock
  localparam int BeatsPerLane = 2;
  localparam int PhyWidth     = NumLanes * BeatsPerLane;

  ////////////////////////////////////////////////////////////
  // Payload framing and buffering
  ////////////////////////////////////////////////////////////

  localparam int PayloadWidth  = 128;
  localparam int PayloadSplits = 4;
  localparam int RecvFifoDepth = 4;
  localparam int RawFifoDepth  = 8;

  // One channel word per beat
  typedef logic [PhyWidth-1:0] phy_data_t;
  // All channels of one beat, channel 0 in the low half
  typedef logic [NumChannels*PhyWidth-1:0] phy_beat_t;
  // Beat 0 sits in the low bits
  typedef logic [PayloadWidth-1:0] payload_t;
  // Raw FIFO usage, 0 up to RawFifoDepth
  typedef logic [$clog2(RawFifoDepth):0] raw_fill_t;

endpackage

// File: source/link_rx.sv
/*
  Link consumer
  Aligns channel beats through a flow-control FIFO and reassembles payloads,
  with direct channel reads in calibration mode
*/
`timescale 1ns/1ps

module link_rx (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  link_format_pkg::phy_beat_t  data_in_i,
  input  link_ctrl_pkg::chan_mask_t   data_in_valid_i,
  output link_ctrl_pkg::chan_mask_t   data_in_ready_o,
  output link_format_pkg::payload_t   payload_out_data_o,
  output logic                        payload_out_valid_o,
  input  logic                        payload_out_ready_i,
  input  logic                        raw_mode_en_i,
  input  link_ctrl_pkg::chan_sel_t    raw_in_sel_i,
  output link_format_pkg::phy_data_t  raw_in_data_o,
  output link_ctrl_pkg::chan_mask_t   raw_in_valid_o,
  input  logic                        raw_in_ready_i,
  input  logic                        flow_clear_i
);

  // Incoming beat split per channel
  link_format_pkg::phy_data_t [link_format_pkg::NumChannels-1:0] chan_words;

  link_format_pkg::phy_beat_t flow_head;
  logic flow_full, flow_empty, flow_push, flow_pop;

  // Assembly slots, beat 0 lands in the low bits of the payload
  link_format_pkg::phy_beat_t [link_format_pkg::PayloadSplits-1:0] slot_q;
  logic [link_format_pkg::PayloadSplits-1:0] slot_full_q, slot_full_d;
  logic [$clog2(link_format_pkg::PayloadSplits)-1:0] wr_idx_q, wr_idx_d;
  logic slot_we, payload_take;

  assign chan_words         = data_in_i;
  assign payload_out_data_o = slot_q;

  ////////////////////////////////////////////////////////////
  // Flow-control buffer
  ////////////////////////////////////////////////////////////

  link_fifo #(
    .DataWidth ( $bits(link_format_pkg::phy_beat_t) ),
    .Depth     ( link_format_pkg::RecvFifoDepth     )
  ) i_flow_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .flush_i  ( flow_clear_i ),
    .push_i   ( flow_push    ),
    .data_i   ( data_in_i    ),
    .pop_i    ( flow_pop     ),
    .data_o   ( flow_head    ),
    .full_o   ( flow_full    ),
    .empty_o  ( flow_empty   ),
    .usage_o  (              )
  );

  ////////////////////////////////////////////////////////////
  // Alignment, assembly and raw access
  ////////////////////////////////////////////////////////////

  always_comb begin
    data_in_ready_o     = '0;
    raw_in_data_o       = '0;
    raw_in_valid_o      = '0;
    flow_push           = 1'b0;
    payload_out_valid_o = 1'b0;
    payload_take        = 1'b0;
    slot_we             = 1'b0;
    wr_idx_d            = wr_idx_q;

    if (raw_mode_en_i) begin
      raw_in_valid_o = data_in_valid_i;
      // Read strobe pops only the selected channel
      if (raw_in_ready_i && data_in_valid_i[raw_in_sel_i]) begin
        data_in_ready_o[raw_in_sel_i] = 1'b1;
        raw_in_data_o                 = chan_words[raw_in_sel_i];
      end
    end else begin
      // Channels move together once all of them hold a word
      flow_push       = (&data_in_valid_i) & ~flow_full;
      data_in_ready_o = {link_format_pkg::NumChannels{flow_push}};

      payload_out_valid_o = &slot_full_q;
      payload_take        = payload_out_valid_o & payload_out_ready_i;

      // A slot freed by this cycle's handshake may be refilled right away
      if (!flow_empty && (!slot_full_q[wr_idx_q] || payload_take)) begin
        slot_we  = 1'b1;
        wr_idx_d = wr_idx_q + 1'b1;
      end
    end
  end

  assign flow_pop = slot_we;

  always_comb begin
    slot_full_d = slot_full_q;
    if (payload_take) begin
      slot_full_d = '0;
    end
    if (slot_we) begin
      slot_full_d[wr_idx_q] = 1'b1;
    end
  end

  // Clearing the flow path also drops a partial assembly
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_full_q <= '0;
      wr_idx_q    <= '0;
    end else if (flow_clear_i) begin
      slot_full_q <= '0;
      wr_idx_q    <= '0;
    end else begin
      slot_full_q <= slot_full_d;
      wr_idx_q    <= wr_idx_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_we) begin
      slot_q[wr_idx_q] <= flow_head;
    end
  end

endmodule

// File: source/link_tx.sv
/*
  Link producer
  Splits each payload into channel beats, or sends buffered raw words
  to a mask of channels in calibration mode
*/
`timescale 1ns/1ps

module link_tx (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  link_format_pkg::payload_t   payload_in_data_i,
  input  logic                        payload_in_valid_i,
  output logic                        payload_in_ready_o,
  output link_format_pkg::phy_beat_t  data_out_o,
  output link_ctrl_pkg::chan_mask_t   data_out_valid_o,
  input  logic                        data_out_ready_i,
  input  logic                        raw_mode_en_i,
  input  link_format_pkg::phy_data_t  raw_out_data_i,
  input  logic                        raw_out_valid_i,
  input  logic                        raw_out_en_i,
  input  link_ctrl_pkg::chan_mask_t   raw_out_mask_i,
  input  logic                        raw_out_clear_i,
  output link_format_pkg::raw_fill_t  raw_out_fill_o,
  output logic                        raw_out_full_o
);

  link_ctrl_pkg::link_send_state_e state_q, state_d;
  logic [$clog2(link_format_pkg::PayloadSplits)-1:0] beat_idx_q, beat_idx_d;
  logic last_beat;

  // Payload viewed as an array of beats
  link_format_pkg::phy_beat_t [link_format_pkg::PayloadSplits-1:0] payload_beats;

  link_format_pkg::phy_data_t raw_head;
  logic raw_full, raw_empty, raw_push, raw_pop;

  assign payload_beats = payload_in_data_i;
  assign last_beat     = (int'(beat_idx_q) == link_format_pkg::PayloadSplits - 1);

  ////////////////////////////////////////////////////////////
  // Raw word buffer
  ////////////////////////////////////////////////////////////

  // Pushes on a full buffer are dropped
  assign raw_push       = raw_out_valid_i & ~raw_full;
  assign raw_out_full_o = raw_full;

  link_fifo #(
    .DataWidth ( link_format_pkg::PhyWidth     ),
    .Depth     ( link_format_pkg::RawFifoDepth )
  ) i_raw_fifo (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .flush_i  ( raw_out_clear_i ),
    .push_i   ( raw_push        ),
    .data_i   ( raw_out_data_i  ),
    .pop_i    ( raw_pop         ),
    .data_o   ( raw_head        ),
    .full_o   ( raw_full        ),
    .empty_o  ( raw_empty       ),
    .usage_o  ( raw_out_fill_o  )
  );

  ////////////////////////////////////////////////////////////
  // Framing FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    beat_idx_d         = beat_idx_q;
    payload_in_ready_o = 1'b0;
    data_out_o         = '0;
    data_out_valid_o   = '0;
    raw_pop            = 1'b0;

    if (raw_mode_en_i) begin
      // Same word on every channel, the mask picks who sends it
      if (raw_out_en_i && !raw_empty) begin
        data_out_valid_o = raw_out_mask_i;
        data_out_o       = {link_format_pkg::NumChannels{raw_head}};
        raw_pop          = data_out_ready_i;
      end
    end else begin
      unique case (state_q)
        link_ctrl_pkg::LinkSendIdle: begin
          // Beat 0 goes out straight from the input
          if (payload_in_valid_i) begin
            data_out_valid_o = '1;
            data_out_o       = payload_beats[beat_idx_q];
            if (data_out_ready_i) begin
              state_d    = link_ctrl_pkg::LinkSendBusy;
              beat_idx_d = beat_idx_q + 1'b1;
            end
          end
        end
        link_ctrl_pkg::LinkSendBusy: begin
          data_out_valid_o = '1;
          data_out_o       = payload_beats[beat_idx_q];
          if (data_out_ready_i) begin
            if (last_beat) begin
              payload_in_ready_o = 1'b1;
              state_d            = link_ctrl_pkg::LinkSendIdle;
              beat_idx_d         = '0;
            end else begin
              beat_idx_d = beat_idx_q + 1'b1;
            end
          end
        end
        default: state_d = link_ctrl_pkg::LinkSendIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= link_ctrl_pkg::LinkSendIdle;
      beat_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      beat_idx_q <= beat_idx_d;
    end
  end

endmodule

// File: source/serial_link_data_link.sv
/*
  Serial link data link layer
  Payload streams on one side, PHY channels on the other
*/
`timescale 1ns/1ps

module serial_link_data_link (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // Payload streams
  input  link_format_pkg::payload_t   payload_in_data_i,
  input  logic                        payload_in_valid_i,
  output logic                        payload_in_ready_o,
  output link_format_pkg::payload_t   payload_out_data_o,
  output logic                        payload_out_valid_o,
  input  logic                        payload_out_ready_i,
  // PHY channels
  output link_format_pkg::phy_beat_t  data_out_o,
  output link_ctrl_pkg::chan_mask_t   data_out_valid_o,
  input  logic                        data_out_ready_i,
  input  link_format_pkg::phy_beat_t  data_in_i,
  input  link_ctrl_pkg::chan_mask_t   data_in_valid_i,
  output link_ctrl_pkg::chan_mask_t   data_in_ready_o,
  // Calibration and flow control
  input  logic                        cfg_raw_mode_en_i,
  input  link_format_pkg::phy_data_t  cfg_raw_out_data_i,
  input  logic                        cfg_raw_out_valid_i,
  input  logic                        cfg_raw_out_en_i,
  input  link_ctrl_pkg::chan_mask_t   cfg_raw_out_mask_i,
  input  logic                        cfg_raw_out_clear_i,
  output link_format_pkg::raw_fill_t  cfg_raw_out_fill_o,
  output logic                        cfg_raw_out_full_o,
  input  link_ctrl_pkg::chan_sel_t    cfg_raw_in_sel_i,
  output link_format_pkg::phy_data_t  cfg_raw_in_data_o,
  output link_ctrl_pkg::chan_mask_t   cfg_raw_in_valid_o,
  input  logic                        cfg_raw_in_ready_i,
  input  logic                        cfg_flow_clear_i
);

  link_tx i_link_tx (
    .clk_i              ( clk_i               ),
    .arst_n_i           ( arst_n_i            ),
    .payload_in_data_i  ( payload_in_data_i   ),
    .payload_in_valid_i ( payload_in_valid_i  ),
    .payload_in_ready_o ( payload_in_ready_o  ),
    .data_out_o         ( data_out_o          ),
    .data_out_valid_o   ( data_out_valid_o    ),
    .data_out_ready_i   ( data_out_ready_i    ),
    .raw_mode_en_i      ( cfg_raw_mode_en_i   ),
    .raw_out_data_i     ( cfg_raw_out_data_i  ),
    .raw_out_valid_i    ( cfg_raw_out_valid_i ),
    .raw_out_en_i       ( cfg_raw_out_en_i    ),
    .raw_out_mask_i     ( cfg_raw_out_mask_i  ),
    .raw_out_clear_i    ( cfg_raw_out_clear_i ),
    .raw_out_fill_o     ( cfg_raw_out_fill_o  ),
    .raw_out_full_o     ( cfg_raw_out_full_o  )
  );

  link_rx i_link_rx (
    .clk_i               ( clk_i               ),
    .arst_n_i            ( arst_n_i            ),
    .data_in_i           ( data_in_i           ),
    .data_in_valid_i     ( data_in_valid_i     ),
    .data_in_ready_o     ( data_in_ready_o     ),
    .payload_out_data_o  ( payload_out_data_o  ),
    .payload_out_valid_o ( payload_out_valid_o ),
    .payload_out_ready_i ( payload_out_ready_i ),
    .raw_mode_en_i       ( cfg_raw_mode_en_i   ),
    .raw_in_sel_i        ( cfg_raw_in_sel_i    ),
    .raw_in_data_o       ( cfg_raw_in_data_o   ),
    .raw_in_valid_o      ( cfg_raw_in_valid_o  ),
    .raw_in_ready_i      ( cfg_raw_in_ready_i  ),
    .flow_clear_i        ( cfg_flow_clear_i    )
  );

endmodule

// File: verification/tb_serial_link_data_link.sv
/*
  Testbench for the serial link data link layer
  Directed tests over a PHY loopback model, plus raw-mode checks
*/
`timescale 1ns/1ps

module tb_serial_link_data_link;

  localparam int PhyW      = link_format_pkg::PhyWidth;
  localparam int WaitLimit = 200;
  localparam int LoopDepth = 4;

  logic clk_i = 1'b0;
  logic arst_n_i;
  link_format_pkg::payload_t  payload_in_data_i, payload_out_data_o;
  logic payload_in_valid_i, payload_in_ready_o, payload_out_valid_o, payload_out_ready_i;
  link_format_pkg::phy_beat_t data_out_o, data_in_i;
  link_ctrl_pkg::chan_mask_t  data_out_valid_o, data_in_valid_i, data_in_ready_o;
  logic data_out_ready_i;
  logic cfg_raw_mode_en_i, cfg_raw_out_valid_i, cfg_raw_out_en_i, cfg_raw_out_clear_i;
  link_format_pkg::phy_data_t cfg_raw_out_data_i, cfg_raw_in_data_o;
  link_ctrl_pkg::chan_mask_t  cfg_raw_out_mask_i, cfg_raw_in_valid_o;
  link_format_pkg::raw_fill_t cfg_raw_out_fill_o;
  logic cfg_raw_out_full_o, cfg_raw_in_ready_i, cfg_flow_clear_i;
  link_ctrl_pkg::chan_sel_t   cfg_raw_in_sel_i;

  // Loopback model and direct PHY drive while it is detached
  logic loop_en;
  link_format_pkg::phy_data_t chan0_q[$], chan1_q[$], lb_drop;
  link_format_pkg::phy_beat_t lb_data, tb_in_data, tx_word;
  link_ctrl_pkg::chan_mask_t  lb_valid, tb_in_valid, tx_mask, rx_take;
  logic lb_ready, tb_out_ready, tx_fire;

  integer seed;
  int errors, tests, failed_tests, mark;

  always #5 clk_i = ~clk_i;

  assign data_in_i        = loop_en ? lb_data  : tb_in_data;
  assign data_in_valid_i  = loop_en ? lb_valid : tb_in_valid;
  assign data_out_ready_i = loop_en ? lb_ready : tb_out_ready;

  serial_link_data_link DUT (.*);

  ////////////////////////////////////////////////////////////
  // PHY loopback with handshakes sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    tx_fire = loop_en && data_out_ready_i && (|data_out_valid_o);
    tx_mask = data_out_valid_o;
    tx_word = data_out_o;
    rx_take = loop_en ? (data_in_ready_o & data_in_valid_i) : '0;
    @(posedge clk_i);
    #1;
    if (rx_take[0]) lb_drop = chan0_q.pop_front();
    if (rx_take[1]) lb_drop = chan1_q.pop_front();
    if (tx_fire && tx_mask[0]) chan0_q.push_back(tx_word[PhyW-1:0]);
    if (tx_fire && tx_mask[1]) chan1_q.push_back(tx_word[2*PhyW-1:PhyW]);
    lb_valid = {chan1_q.size() > 0, chan0_q.size() > 0};
    lb_data[PhyW-1:0]      = (chan0_q.size() > 0) ? chan0_q[0] : '0;
    lb_data[2*PhyW-1:PhyW] = (chan1_q.size() > 0) ? chan1_q[0] : '0;
    lb_ready = (chan0_q.size() < LoopDepth) && (chan1_q.size() < LoopDepth);
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_payload(input string name, input link_format_pkg::payload_t exp,
                               input link_format_pkg::payload_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_phy(input string name, input link_format_pkg::phy_data_t exp,
                           input link_format_pkg::phy_data_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_fill(input string name, input link_format_pkg::raw_fill_t exp,
                            input link_format_pkg::raw_fill_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input link_ctrl_pkg::chan_mask_t exp,
                            input link_ctrl_pkg::chan_mask_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers called just after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic timeout_report(input string what);
    $display("timeout at %0t ns: %s did not happen within %0d cycles", $time, what, WaitLimit);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == mark) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - mark);
    end
    mark = errors;
  endtask

  task automatic make_payload(output link_format_pkg::payload_t p);
    p = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic send_payload(input link_format_pkg::payload_t p);
    int  waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    payload_in_data_i  = p;
    payload_in_valid_i = 1'b1;
    while (!done && waited < WaitLimit) begin
      @(negedge clk_i);
      if (payload_in_ready_o) done = 1'b1;
      else waited++;
    end
    @(posedge clk_i);
    #1;
    payload_in_valid_i = 1'b0;
    if (!done) timeout_report("payload input handshake");
  endtask

  task automatic recv_payload(output link_format_pkg::payload_t p);
    int  waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    p      = '0;
    payload_out_ready_i = 1'b1;
    while (!done && waited < WaitLimit) begin
      @(negedge clk_i);
      if (payload_out_valid_o) begin
        done = 1'b1;
        p    = payload_out_data_o;
      end else begin
        waited++;
      end
    end
    @(posedge clk_i);
    #1;
    payload_out_ready_i = 1'b0;
    if (!done) timeout_report("payload output handshake");
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((chan0_q.size() + chan1_q.size()) != 0 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if ((chan0_q.size() + chan1_q.size()) != 0) timeout_report("loopback drain");
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_raw_out(output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    while (!ok && waited < WaitLimit) begin
      @(negedge clk_i);
      if (|data_out_valid_o) ok = 1'b1;
      else waited++;
    end
    if (!ok) timeout_report("raw word on data_out_valid_o");
  endtask

  // Extra output payloads would show up here as valid
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("payload_out_valid_o", 1'b0, payload_out_valid_o);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic push_raw(input link_format_pkg::phy_data_t w);
    cfg_raw_out_data_i  = w;
    cfg_raw_out_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_raw_out_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_bit("payload_in_ready_o", 1'b0, payload_in_ready_o);
    check_bit("payload_out_valid_o", 1'b0, payload_out_valid_o);
    check_mask("data_out_valid_o", '0, data_out_valid_o);
    check_mask("data_in_ready_o", '0, data_in_ready_o);
    check_mask("cfg_raw_in_valid_o", '0, cfg_raw_in_valid_o);
    check_bit("cfg_raw_out_full_o", 1'b0, cfg_raw_out_full_o);
    check_fill("cfg_raw_out_fill_o", '0, cfg_raw_out_fill_o);
    end_test("reset");
  endtask

  task automatic test_loopback();
    link_format_pkg::payload_t sent[8];
    link_format_pkg::payload_t got;
    for (int i = 0; i < 8; i++) make_payload(sent[i]);
    fork
      for (int i = 0; i < 8; i++) send_payload(sent[i]);
      for (int j = 0; j < 8; j++) begin
        recv_payload(got);
        check_payload("payload_out_data_o", sent[j], got);
      end
    join
    expect_quiet(8);
    end_test("loopback");
  endtask

  task automatic test_back_pressure();
    link_format_pkg::payload_t sent[3];
    link_format_pkg::payload_t got;
    // Slots, flow FIFO and PHY queues each end up holding one payload
    for (int i = 0; i < 3; i++) begin
      make_payload(sent[i]);
      send_payload(sent[i]);
    end
    for (int i = 0; i < 3; i++) begin
      recv_payload(got);
      check_payload("payload_out_data_o", sent[i], got);
    end
    expect_quiet(8);
    end_test("back_pressure");
  endtask

  task automatic test_flow_clear();
    link_format_pkg::payload_t stale, fresh, got;
    make_payload(stale);
    send_payload(stale);
    make_payload(stale);
    send_payload(stale);
    wait_drained();
    cfg_flow_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_flow_clear_i = 1'b0;
    check_bit("payload_out_valid_o", 1'b0, payload_out_valid_o);
    make_payload(fresh);
    send_payload(fresh);
    recv_payload(got);
    check_payload("payload_out_data_o", fresh, got);
    end_test("flow_clear");
  endtask

  task automatic test_raw_tx();
    link_format_pkg::phy_data_t words[8];
    logic ok;
    loop_en           = 1'b0;
    tb_out_ready      = 1'b0;
    cfg_raw_mode_en_i = 1'b1;
    for (int i = 0; i < 8; i++) words[i] = $random(seed);
    for (int i = 0; i < 5; i++) push_raw(words[i]);
    check_fill("cfg_raw_out_fill_o", 5, cfg_raw_out_fill_o);
    check_mask("data_out_valid_o", '0, data_out_valid_o);
    cfg_raw_out_mask_i = 2'b10;
    cfg_raw_out_en_i   = 1'b1;
    tb_out_ready       = 1'b1;
    for (int i = 0; i < 5; i++) begin
      wait_raw_out(ok);
      if (ok) begin
        check_mask("data_out_valid_o", 2'b10, data_out_valid_o);
        check_phy("data_out_o channel 1", words[i], data_out_o[2*PhyW-1:PhyW]);
      end
      @(posedge clk_i);
      #1;
    end
    cfg_raw_out_en_i = 1'b0;
    tb_out_ready     = 1'b0;
    check_fill("cfg_raw_out_fill_o", 0, cfg_raw_out_fill_o);
    for (int i = 0; i < 8; i++) push_raw(words[i]);
    check_bit("cfg_raw_out_full_o", 1'b1, cfg_raw_out_full_o);
    push_raw(~words[0]);
    check_fill("cfg_raw_out_fill_o", 8, cfg_raw_out_fill_o);
    cfg_raw_out_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_raw_out_clear_i = 1'b0;
    check_fill("cfg_raw_out_fill_o", 0, cfg_raw_out_fill_o);
    check_bit("cfg_raw_out_full_o", 1'b0, cfg_raw_out_full_o);
    end_test("raw_tx");
  endtask

  task automatic test_raw_rx();
    tb_in_data       = {16'h5a3c, 16'hc3a5};
    tb_in_valid      = 2'b11;
    cfg_raw_in_sel_i = 1'b1;
    @(negedge clk_i);
    check_mask("cfg_raw_in_valid_o", 2'b11, cfg_raw_in_valid_o);
    check_mask("data_in_ready_o", 2'b00, data_in_ready_o);
    @(posedge clk_i);
    #1;
    cfg_raw_in_ready_i = 1'b1;
    @(negedge clk_i);
    check_phy("cfg_raw_in_data_o", 16'h5a3c, cfg_raw_in_data_o);
    check_mask("data_in_ready_o", 2'b10, data_in_ready_o);
    @(posedge clk_i);
    #1;
    cfg_raw_in_ready_i = 1'b0;
    tb_in_valid        = '0;
    cfg_raw_mode_en_i  = 1'b0;
    end_test("raw_rx");
  endtask

  initial begin
    seed = 60218;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    mark = 0;
    arst_n_i = 1'b0;
    payload_in_data_i = '0;
    payload_in_valid_i = 1'b0;
    payload_out_ready_i = 1'b0;
    cfg_raw_mode_en_i = 1'b0;
    cfg_raw_out_data_i = '0;
    cfg_raw_out_valid_i = 1'b0;
    cfg_raw_out_en_i = 1'b0;
    cfg_raw_out_mask_i = '0;
    cfg_raw_out_clear_i = 1'b0;
    cfg_raw_in_sel_i = '0;
    cfg_raw_in_ready_i = 1'b0;
    cfg_flow_clear_i = 1'b0;
    loop_en = 1'b1;
    lb_data = '0;
    lb_valid = '0;
    lb_ready = 1'b1;
    tb_in_data = '0;
    tb_in_valid = '0;
    tb_out_ready = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    test_reset();
    test_loopback();
    test_back_pressure();
    test_flow_clear();
    test_raw_tx();
    test_raw_rx();
    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
